/* Makefile */
# Verilator build and run of the UART command memory testbench

TOP := tb_soc

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP), fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

/* common/soc_pkg.sv */
package soc_pkg;

   // host command opcodes, ascii 'W' and 'R'
   localparam logic [7:0] OP_WRITE = 8'h57;
   localparam logic [7:0] OP_READ = 8'h52;

   // write acknowledge, ascii 'K'
   localparam logic [7:0] REPLY_ACK = 8'h4B;

   // byte strobe towards the transmitter
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } uart_byte_t;

   // received byte with its stop bit check
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
      logic       frame_err;
   } rx_byte_t;

endpackage

/* design/cmd_engine.sv */
`timescale 1ns/100ps

module cmd_engine #(
   parameter int MEM_ADDR_W = 4
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                rst_i,
   input  soc_pkg::rx_byte_t   rx_byte_i,
   input  logic                tx_busy_i,
   output soc_pkg::uart_byte_t tx_req_o,
   output logic                trap_o
);

   localparam int MEM_DEPTH = 1 << MEM_ADDR_W;

   typedef enum logic [1:0] {
      ST_OPCODE,
      ST_ADDR,
      ST_DATA
   } cmd_state_t;

   cmd_state_t            state_q;
   cmd_state_t            state_d;
   logic                  is_wr_q;
   logic                  is_wr_d;
   logic [MEM_ADDR_W-1:0] addr_q;
   logic [MEM_ADDR_W-1:0] addr_d;
   logic [7:0]            mem [MEM_DEPTH];
   logic                  mem_we;
   logic                  push;
   logic [7:0]            push_data;
   logic                  err;
   logic                  overflow;
   logic                  pend_valid_q;
   logic [7:0]            pend_data_q;
   logic                  trap_q;

   always_comb begin
      state_d = state_q;
      is_wr_d = is_wr_q;
      addr_d = addr_q;
      mem_we = 1'b0;
      push = 1'b0;
      push_data = soc_pkg::REPLY_ACK;
      err = 1'b0;
      if (rx_byte_i.valid) begin
         if (rx_byte_i.frame_err) begin
            err = 1'b1;
            state_d = ST_OPCODE;
         end else begin
            unique case (state_q)
               ST_OPCODE: begin
                  if (rx_byte_i.data == soc_pkg::OP_WRITE) begin
                     is_wr_d = 1'b1;
                     state_d = ST_ADDR;
                  end else if (rx_byte_i.data == soc_pkg::OP_READ) begin
                     is_wr_d = 1'b0;
                     state_d = ST_ADDR;
                  end else begin
                     err = 1'b1;
                  end
               end
               ST_ADDR: begin
                  state_d = ST_OPCODE;
                  if (int'(rx_byte_i.data) >= MEM_DEPTH) begin
                     err = 1'b1;
                  end else if (is_wr_q) begin
                     addr_d = rx_byte_i.data[MEM_ADDR_W-1:0];
                     state_d = ST_DATA;
                  end else begin
                     // read reply comes straight out of the array
                     push = 1'b1;
                     push_data = mem[rx_byte_i.data[MEM_ADDR_W-1:0]];
                  end
               end
               ST_DATA: begin
                  mem_we = 1'b1;
                  push = 1'b1;
                  state_d = ST_OPCODE;
               end
               default: state_d = ST_OPCODE;
            endcase
         end
      end
   end

   // pending slot can only take a new reply once the old one is leaving
   assign overflow = push && pend_valid_q && tx_busy_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_OPCODE;
         pend_valid_q <= 1'b0;
         trap_q <= 1'b0;
      end else if (rst_i) begin
         state_q <= ST_OPCODE;
         pend_valid_q <= 1'b0;
         trap_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (push && !overflow) begin
            pend_valid_q <= 1'b1;
         end else if (tx_req_o.valid) begin
            pend_valid_q <= 1'b0;
         end
         // sticky until the next reset
         if (err || overflow) begin
            trap_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      is_wr_q <= is_wr_d;
      addr_q <= addr_d;
      if (push && !overflow) begin
         pend_data_q <= push_data;
      end
      if (mem_we) begin
         mem[addr_q] <= rx_byte_i.data;
      end
   end

   assign tx_req_o.valid = pend_valid_q && !tx_busy_i;
   assign tx_req_o.data = pend_data_q;
   assign trap_o = trap_q;

   // host waits for each reply, so a second reply never piles up
   a_no_pending_overflow: assert property (
      @(posedge clk_i) disable iff (!rst_n_i || rst_i)
      !(push && pend_valid_q && tx_busy_i)
   ) else $error("reply pushed while pending reply still waiting");

endmodule

/* design/reset_pulse_gen.sv */
`timescale 1ns/100ps

module reset_pulse_gen #(
   parameter int RST_START = 5,
   parameter int RST_DURATION = 10
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic start_i,
   output logic rst_o
);

   // reset stays high through the start delay and then the pulse itself
   localparam int TOTAL = RST_START + RST_DURATION;
   localparam int CNT_W = $clog2(TOTAL + 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TOTAL - 1);

   logic [CNT_W-1:0] cnt_q;
   logic             rst_q;

   // counter stops once the pulse is over, so it saturates at TOTAL
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
         rst_q <= 1'b1;
      end else if (!start_i) begin
         cnt_q <= '0;
         rst_q <= 1'b1;
      end else if (rst_q) begin
         cnt_q <= cnt_q + 1'b1;
         if (cnt_q == CNT_LAST) begin
            rst_q <= 1'b0;
         end
      end
   end

   assign rst_o = rst_q;

   // no second pulse without a new external reset
   a_rst_stays_low: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (!rst_o && start_i) |=> !rst_o
   ) else $error("internal reset reasserted without external reset");

endmodule

/* design/reset_sync.sv */
`timescale 1ns/100ps

module reset_sync (
   input  logic clk_i,
   input  logic rst_n_i,
   output logic start_o
);

   logic [1:0] sync_q;

   // assert asynchronously, release on the second clock edge
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync_q <= 2'b00;
      end else begin
         sync_q <= {sync_q[0], 1'b1};
      end
   end

   assign start_o = sync_q[1];

   // a reset seen at one edge must still hold start low at the next
   a_start_low_after_reset: assert property (
      @(posedge clk_i) !rst_n_i |=> !start_o
   ) else $error("start_o high in the cycle after reset");

endmodule

/* design/soc_fpga_wrapper.sv */
`timescale 1ns/100ps

module soc_fpga_wrapper #(
   parameter int CLKS_PER_BIT = 8,
   parameter int MEM_ADDR_W = 4,
   parameter int RST_START = 5,
   parameter int RST_DURATION = 10
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic uart_rxd_i,
   output logic uart_txd_o,
   output logic trap_o
);

   logic                start;
   logic                rst;
   soc_pkg::rx_byte_t   rx_byte;
   soc_pkg::uart_byte_t tx_req;
   logic                tx_busy;

   reset_sync u_reset_sync (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .start_o(start)
   );

   // board reset pin may never be pressed, so a pulse is generated
   reset_pulse_gen #(
      .RST_START   (RST_START),
      .RST_DURATION(RST_DURATION)
   ) u_reset_pulse_gen (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .start_i(start),
      .rst_o  (rst)
   );

   uart_rx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) u_uart_rx (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .rst_i    (rst),
      .rxd_i    (uart_rxd_i),
      .rx_byte_o(rx_byte)
   );

   uart_tx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) u_uart_tx (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .rst_i   (rst),
      .tx_req_i(tx_req),
      .busy_o  (tx_busy),
      .txd_o   (uart_txd_o)
   );

   cmd_engine #(
      .MEM_ADDR_W(MEM_ADDR_W)
   ) u_cmd_engine (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .rst_i    (rst),
      .rx_byte_i(rx_byte),
      .tx_busy_i(tx_busy),
      .tx_req_o (tx_req),
      .trap_o   (trap_o)
   );

endmodule

/* files.f */
common/soc_pkg.sv
design/reset_sync.sv
design/reset_pulse_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/cmd_engine.sv
design/soc_fpga_wrapper.sv
test/tb_soc.sv

/* test/tb_soc.sv */
`timescale 1ns/100ps

module tb_soc;

   localparam int CLKS_PER_BIT = 8;
   localparam int MEM_ADDR_W = 4;
   localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;

   // one row of the stimulus table
   typedef struct packed {
      logic [7:0] opcode;
      logic [7:0] addr;
      logic [7:0] data;
      logic [1:0] n_bytes;
      logic       bad_stop;
      logic       exp_reply;
      logic [7:0] reply;
      logic       exp_trap;
   } vec_t;

   logic clk = 1'b0;
   logic rst_n = 1'b0;
   logic uart_rxd = 1'b1;
   logic uart_txd;
   logic trap;

   vec_t       vecs[$];
   string      names[$];
   logic [7:0] sb [1 << MEM_ADDR_W];
   int         seed = 32'h7a074c86;
   int         cycle_cnt = 0;
   int         cycle_limit = 200;

   soc_fpga_wrapper #(
      .CLKS_PER_BIT(CLKS_PER_BIT),
      .MEM_ADDR_W  (MEM_ADDR_W)
   ) u_soc_fpga_wrapper (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .uart_rxd_i(uart_rxd),
      .uart_txd_o(uart_txd),
      .trap_o    (trap)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout: no reply from UART within %0d cycles", cycle_limit);
         $display("TESTS FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic check_reply(input string name, input soc_pkg::uart_byte_t exp,
                              input soc_pkg::uart_byte_t act);
      if (act !== exp) begin
         $display("Fail %s: expected valid=%0b data=%02h, actual valid=%0b data=%02h",
                  name, exp.valid, exp.data, act.valid, act.data);
         $display("TESTS FAILED");
         $fatal(1, "reply mismatch");
      end
   endtask

   task automatic check_trap(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: expected trap=%0b, actual trap=%0b", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1, "trap mismatch");
      end
   endtask

   task automatic check_line(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: expected txd=%0b, actual txd=%0b", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1, "line level mismatch");
      end
   endtask

   // txd idle and trap clear all through the reset sequence
   task automatic apply_reset(input string name);
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (2) begin
         @(posedge clk);
         check_line({name, " txd in reset"}, 1'b1, uart_txd);
         check_trap({name, " trap in reset"}, 1'b0, trap);
      end
      rst_n <= 1'b1;
      repeat (20) begin
         @(posedge clk);
         check_line({name, " txd after reset"}, 1'b1, uart_txd);
         check_trap({name, " trap after reset"}, 1'b0, trap);
      end
   endtask

   // host side frame of start, 8 data bits lsb first and stop
   task automatic send_byte(input logic [7:0] data, input logic bad_stop);
      logic [9:0] frame;
      frame = {~bad_stop, data, 1'b0};
      repeat (10) begin
         @(posedge clk);
         uart_rxd <= frame[0];
         frame = {1'b1, frame[9:1]};
         repeat (CLKS_PER_BIT - 1) @(posedge clk);
      end
      @(posedge clk);
      uart_rxd <= 1'b1;
   endtask

   // valid stays low when no start bit shows up in time
   task automatic wait_reply(input string name, input int max_cycles,
                             output soc_pkg::uart_byte_t rep);
      int         waited;
      logic       found;
      logic [7:0] data;
      waited = 0;
      found = 1'b0;
      data = 8'h00;
      rep = '0;
      while (!found && waited < max_cycles) begin
         @(posedge clk);
         waited++;
         if (!uart_txd) begin
            found = 1'b1;
         end
      end
      if (found) begin
         repeat (CLKS_PER_BIT / 2) @(posedge clk);
         repeat (8) begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            data = {uart_txd, data[7:1]};
         end
         repeat (CLKS_PER_BIT) @(posedge clk);
         check_line({name, " reply stop bit"}, 1'b1, uart_txd);
         rep.valid = 1'b1;
         rep.data = data;
      end
   endtask

   task automatic add_write(input string name, input logic [7:0] addr);
      vec_t v;
      v.opcode = soc_pkg::OP_WRITE;
      v.addr = addr;
      v.data = 8'($random(seed));
      v.n_bytes = 2'd3;
      v.bad_stop = 1'b0;
      v.exp_reply = 1'b1;
      v.reply = soc_pkg::REPLY_ACK;
      v.exp_trap = 1'b0;
      sb[addr[MEM_ADDR_W-1:0]] = v.data;
      vecs.push_back(v);
      names.push_back(name);
   endtask

   // expected byte is whatever the scoreboard holds at this point
   task automatic add_read(input string name, input logic [7:0] addr);
      vec_t v;
      v.opcode = soc_pkg::OP_READ;
      v.addr = addr;
      v.data = 8'h00;
      v.n_bytes = 2'd2;
      v.bad_stop = 1'b0;
      v.exp_reply = 1'b1;
      v.reply = sb[addr[MEM_ADDR_W-1:0]];
      v.exp_trap = 1'b0;
      vecs.push_back(v);
      names.push_back(name);
   endtask

   task automatic add_error(input string name, input logic [7:0] opcode,
                            input logic [7:0] addr, input logic [1:0] n_bytes,
                            input logic bad_stop);
      vec_t v;
      v.opcode = opcode;
      v.addr = addr;
      v.data = 8'h00;
      v.n_bytes = n_bytes;
      v.bad_stop = bad_stop;
      v.exp_reply = 1'b0;
      v.reply = 8'h00;
      v.exp_trap = 1'b1;
      vecs.push_back(v);
      names.push_back(name);
   endtask

   initial begin
      vec_t                v;
      soc_pkg::uart_byte_t rep;
      soc_pkg::uart_byte_t exp;

      add_write("write addr 0", 8'h00);
      add_write("write addr 3", 8'h03);
      add_write("write addr 7", 8'h07);
      add_write("write addr 15", 8'h0F);
      add_read("read addr 0", 8'h00);
      add_read("read addr 3", 8'h03);
      add_read("read addr 7", 8'h07);
      add_read("read addr 15", 8'h0F);
      add_write("rewrite addr 3", 8'h03);
      add_read("read rewritten addr 3", 8'h03);
      // each error row is followed by a reset
      add_error("illegal opcode", 8'h41, 8'h00, 2'd1, 1'b0);
      add_error("write addr out of range", soc_pkg::OP_WRITE, 8'h10, 2'd2, 1'b0);
      add_error("read addr out of range", soc_pkg::OP_READ, 8'h20, 2'd2, 1'b0);
      add_error("low stop bit", soc_pkg::OP_WRITE, 8'h00, 2'd1, 1'b1);
      // 5 frames per row covers bytes, reply window and reset
      cycle_limit = vecs.size() * 5 * FRAME_CYCLES + 200;

      apply_reset("power on");

      for (int i = 0; i < vecs.size(); i++) begin
         v = vecs[i];
         send_byte(v.opcode, v.bad_stop);
         if (v.n_bytes >= 2'd2) begin
            send_byte(v.addr, 1'b0);
         end
         if (v.n_bytes == 2'd3) begin
            send_byte(v.data, 1'b0);
         end
         wait_reply(names[i], 2 * FRAME_CYCLES, rep);
         exp.valid = v.exp_reply;
         exp.data = v.exp_reply ? v.reply : 8'h00;
         check_reply(names[i], exp, rep);
         check_trap(names[i], v.exp_trap, trap);
         if (v.exp_trap) begin
            apply_reset(names[i]);
         end
      end

      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* uart/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
   parameter int CLKS_PER_BIT = 8
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              rst_i,
   input  logic              rxd_i,
   output soc_pkg::rx_byte_t rx_byte_o
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_START,
      ST_DATA,
      ST_STOP
   } rx_state_t;

   rx_state_t        state_q;
   logic [1:0]       rxd_sync_q;
   logic             rxd_s;
   logic [CNT_W-1:0] cnt_q;
   logic [2:0]       bit_cnt_q;
   logic             bit_tick;
   logic             valid_q;
   logic [7:0]       shift_q;
   logic             ferr_q;

   assign rxd_s = rxd_sync_q[1];
   assign bit_tick = (cnt_q == BIT_LAST);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rxd_sync_q <= 2'b11;
         state_q <= ST_IDLE;
         cnt_q <= '0;
         bit_cnt_q <= '0;
         valid_q <= 1'b0;
      end else if (rst_i) begin
         rxd_sync_q <= 2'b11;
         state_q <= ST_IDLE;
         cnt_q <= '0;
         bit_cnt_q <= '0;
         valid_q <= 1'b0;
      end else begin
         rxd_sync_q <= {rxd_sync_q[0], rxd_i};
         valid_q <= 1'b0;
         cnt_q <= cnt_q + 1'b1;
         unique case (state_q)
            ST_IDLE: begin
               cnt_q <= '0;
               if (!rxd_s) begin
                  state_q <= ST_START;
               end
            end
            ST_START: begin
               // recheck the line half a bit in, a glitch goes back to idle
               if (cnt_q == HALF_LAST) begin
                  cnt_q <= '0;
                  bit_cnt_q <= '0;
                  state_q <= rxd_s ? ST_IDLE : ST_DATA;
               end
            end
            ST_DATA: begin
               if (bit_tick) begin
                  cnt_q <= '0;
                  bit_cnt_q <= bit_cnt_q + 1'b1;
                  if (bit_cnt_q == 3'd7) begin
                     state_q <= ST_STOP;
                  end
               end
            end
            ST_STOP: begin
               // strobe lands in the middle of the stop bit
               if (bit_tick) begin
                  valid_q <= 1'b1;
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk_i) begin
      if (state_q == ST_DATA && bit_tick) begin
         shift_q <= {rxd_s, shift_q[7:1]};
      end
      if (state_q == ST_STOP && bit_tick) begin
         ferr_q <= !rxd_s;
      end
   end

   assign rx_byte_o.valid = valid_q;
   assign rx_byte_o.data = shift_q;
   assign rx_byte_o.frame_err = ferr_q;

   a_valid_single_cycle: assert property (
      @(posedge clk_i) disable iff (!rst_n_i || rst_i)
      rx_byte_o.valid |=> !rx_byte_o.valid
   ) else $error("rx valid held for more than one cycle");

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 8
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                rst_i,
   input  soc_pkg::uart_byte_t tx_req_i,
   output logic                busy_o,
   output logic                txd_o
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

   logic [9:0]       frame_q;
   logic [CNT_W-1:0] cnt_q;
   logic [3:0]       bit_cnt_q;
   logic             busy_q;

   // frame_q[0] is the line, ones shift in behind the stop bit
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         frame_q <= '1;
         cnt_q <= '0;
         bit_cnt_q <= '0;
         busy_q <= 1'b0;
      end else if (rst_i) begin
         frame_q <= '1;
         cnt_q <= '0;
         bit_cnt_q <= '0;
         busy_q <= 1'b0;
      end else if (!busy_q) begin
         if (tx_req_i.valid) begin
            frame_q <= {1'b1, tx_req_i.data, 1'b0};
            cnt_q <= '0;
            bit_cnt_q <= '0;
            busy_q <= 1'b1;
         end
      end else if (cnt_q == BIT_LAST) begin
         cnt_q <= '0;
         frame_q <= {1'b1, frame_q[9:1]};
         bit_cnt_q <= bit_cnt_q + 1'b1;
         // busy drops at the end of the stop bit
         if (bit_cnt_q == 4'd9) begin
            busy_q <= 1'b0;
         end
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign busy_o = busy_q;
   assign txd_o = frame_q[0];

   // the command engine holds replies back while a frame is on the line
   a_no_req_while_busy: assert property (
      @(posedge clk_i) disable iff (!rst_n_i || rst_i)
      tx_req_i.valid |-> !busy_o
   ) else $error("tx request while transmitter busy");

endmodule
